// File: source/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// clk cycles per quarter of an scl period
`define EE_QUARTER_CYCLES 2

// device type code in the top nibble of every control byte
`define EE_DEVICE_CODE 4'b1010

`endif

// File: source/eeprom_pkg.sv
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;  // byte address, top 3 bits are block bits
    typedef logic [7:0]  ee_byte_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } ee_op_t;

    typedef struct packed {
        ee_op_t   op;
        ee_addr_t addr;
        ee_byte_t data;
    } eeprom_req_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_t;

    typedef struct packed {
        bus_cmd_t cmd;
        ee_byte_t data;
    } bus_req_t;

    typedef struct packed {
        ee_byte_t data;
        logic     ack_ok;  // slave held sda low in the ninth bit
    } bus_res_t;

    typedef struct packed {
        ee_op_t   op;
        ee_byte_t data;
        logic     nack;
    } eeprom_res_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_REPORT
    } seq_state_t;

endpackage

// File: source/eeprom_request.sv
`timescale 1ns/1ps

module eeprom_request
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::ee_addr_t    addr,
    input  eeprom_pkg::ee_byte_t    wr_data,
    input  logic                    finish,
    output eeprom_pkg::eeprom_req_t req,
    output logic                    pending
);

    logic capture;

    assign capture = !pending && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pending <= 1'b0;
        end
        else if (pending)
        begin
            if (finish)
                pending <= 1'b0;
        end
        else if (capture)
        begin
            pending <= 1'b1;
        end
    end

    // held for the whole transfer, host may change addr and wr_data meanwhile
    always_ff @(posedge CLK)
    begin
        if (capture)
        begin
            req.op   <= wr ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;  // write wins
            req.addr <= addr;
            req.data <= wr_data;
        end
    end

endmodule

// File: source/eeprom_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    pending,
    output logic                    bus_go,
    output eeprom_pkg::bus_req_t    bus_req,
    input  logic                    bus_done,
    input  eeprom_pkg::bus_res_t    bus_res,
    output logic                    finish,
    output eeprom_pkg::eeprom_res_t result
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t next_state;
    logic                   waiting;  // one bus command in flight
    logic                   nack;
    logic                   rd_dir;
    eeprom_pkg::ee_byte_t   ctrl_byte;
    eeprom_pkg::ee_byte_t   rx_byte;

    assign rd_dir    = (state == eeprom_pkg::S_CTRL_RD);
    assign ctrl_byte = {`EE_DEVICE_CODE, req.addr[10:8], rd_dir};

    always_comb
    begin
        bus_req.cmd  = eeprom_pkg::CMD_WRITE;
        bus_req.data = ctrl_byte;
        case (state)
            eeprom_pkg::S_START,
            eeprom_pkg::S_RESTART:
                bus_req.cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::S_ADDR:
                bus_req.data = req.addr[7:0];  // word address
            eeprom_pkg::S_DATA_WR:
                bus_req.data = req.data;
            eeprom_pkg::S_DATA_RD:
                bus_req.cmd = eeprom_pkg::CMD_READ;
            eeprom_pkg::S_STOP:
                bus_req.cmd = eeprom_pkg::CMD_STOP;
            default:
                bus_req.cmd = eeprom_pkg::CMD_WRITE;
        endcase
    end

    // a missing ack on any written byte falls through to stop
    always_comb
    begin
        next_state = eeprom_pkg::S_STOP;
        case (state)
            eeprom_pkg::S_START:
                next_state = eeprom_pkg::S_CTRL_WR;
            eeprom_pkg::S_CTRL_WR:
                if (bus_res.ack_ok)
                    next_state = eeprom_pkg::S_ADDR;
            eeprom_pkg::S_ADDR:
                if (bus_res.ack_ok)
                begin
                    if (req.op == eeprom_pkg::OP_READ)
                        next_state = eeprom_pkg::S_RESTART;  // dummy write done
                    else
                        next_state = eeprom_pkg::S_DATA_WR;
                end
            eeprom_pkg::S_RESTART:
                next_state = eeprom_pkg::S_CTRL_RD;
            eeprom_pkg::S_CTRL_RD:
                if (bus_res.ack_ok)
                    next_state = eeprom_pkg::S_DATA_RD;
            eeprom_pkg::S_STOP:
                next_state = eeprom_pkg::S_REPORT;
            default:
                next_state = eeprom_pkg::S_STOP;
        endcase
    end

    assign bus_go = !waiting
                 && (state != eeprom_pkg::S_IDLE)
                 && (state != eeprom_pkg::S_REPORT);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= eeprom_pkg::S_IDLE;
            waiting <= 1'b0;
            nack    <= 1'b0;
        end
        else
        begin
            if (bus_go)
                waiting <= 1'b1;
            if (bus_done)
                waiting <= 1'b0;

            case (state)
                eeprom_pkg::S_IDLE:
                    if (pending)
                    begin
                        state <= eeprom_pkg::S_START;
                        nack  <= 1'b0;
                    end
                eeprom_pkg::S_REPORT:
                    state <= eeprom_pkg::S_IDLE;
                default:
                    if (bus_done)
                        state <= next_state;
            endcase

            if (bus_done && bus_req.cmd == eeprom_pkg::CMD_WRITE && !bus_res.ack_ok)
                nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bus_done && state == eeprom_pkg::S_DATA_RD)
            rx_byte <= bus_res.data;
    end

    assign finish = (state == eeprom_pkg::S_REPORT);

    assign result.op   = req.op;
    assign result.data = rx_byte;
    assign result.nack = nack;

endmodule

// File: source/eeprom_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 bus_go,
    input  eeprom_pkg::bus_req_t bus_req,
    output logic                 bus_done,
    output eeprom_pkg::bus_res_t bus_res,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);

    localparam int QW   = $clog2(`EE_QUARTER_CYCLES + 1);
    localparam int QMAX = `EE_QUARTER_CYCLES - 1;

    logic                 active;
    logic [QW-1:0]        qcnt;
    logic [5:0]           phase;      // quarter index, bit = phase[5:2]
    logic [5:0]           phase_nxt;
    logic                 tick;
    logic                 last;
    logic                 sda_next;
    logic                 ack_ok;
    eeprom_pkg::bus_cmd_t cmd;
    eeprom_pkg::ee_byte_t shreg;      // shared for send and receive

    assign tick      = active && (qcnt == QW'(QMAX));
    assign phase_nxt = phase + 6'd1;
    assign last      = (cmd == eeprom_pkg::CMD_START || cmd == eeprom_pkg::CMD_STOP)
                     ? (phase == 6'd3) : (phase == 6'd35);

    // sda level for quarter 1, where scl is low
    always_comb
    begin
        sda_next = 1'b0;
        case (cmd)
            eeprom_pkg::CMD_STOP:
                sda_next = 1'b1;
            eeprom_pkg::CMD_WRITE:
                if (phase_nxt[5:2] != 4'd8)
                    sda_next = ~shreg[7];
            default:
                sda_next = 1'b0;  // start and read release, read ends with nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            bus_done      <= 1'b0;
            qcnt          <= '0;
            phase         <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            bus_done <= 1'b0;
            if (!active)
            begin
                if (bus_go)
                begin
                    active <= 1'b1;
                    qcnt   <= '0;
                    phase  <= '0;
                    scl    <= 1'b0;
                end
            end
            else if (!tick)
            begin
                qcnt <= qcnt + 1'b1;
            end
            else
            begin
                qcnt <= '0;
                if (last)
                begin
                    active   <= 1'b0;
                    bus_done <= 1'b1;  // scl left high
                end
                else
                begin
                    phase <= phase_nxt;
                    case (phase_nxt[1:0])
                        2'd0: scl <= 1'b0;
                        2'd1: sda_drive_low <= sda_next;
                        2'd2: scl <= 1'b1;
                        default:
                            if (cmd == eeprom_pkg::CMD_START)
                                sda_drive_low <= 1'b1;  // falls with scl high
                            else if (cmd == eeprom_pkg::CMD_STOP)
                                sda_drive_low <= 1'b0;  // rises with scl high
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && bus_go)
        begin
            cmd   <= bus_req.cmd;
            shreg <= bus_req.data;
        end
        else if (tick && !last)
        begin
            if (phase_nxt[1:0] == 2'd1 && cmd == eeprom_pkg::CMD_WRITE
                && phase_nxt[5:2] != 4'd8)
                shreg <= shreg << 1;
            if (phase_nxt[1:0] == 2'd3)  // middle of scl high
            begin
                if (phase[5:2] == 4'd8)
                    ack_ok <= !sda_in;
                else if (cmd == eeprom_pkg::CMD_READ)
                    shreg <= {shreg[6:0], sda_in};
            end
        end
    end

    assign bus_res.data   = shreg;
    assign bus_res.ack_ok = ack_ok;

endmodule

// File: source/eeprom_response.sv
`timescale 1ns/1ps

module eeprom_response
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    finish,
    input  eeprom_pkg::eeprom_res_t result,
    output eeprom_pkg::ee_byte_t    rd_data,
    output logic                    nack_err,
    output logic                    done
);

    logic good_read;

    assign good_read = (result.op == eeprom_pkg::OP_READ) && !result.nack;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            done     <= 1'b0;
            nack_err <= 1'b0;
            rd_data  <= '0;
        end
        else
        begin
            done <= finish;
            if (finish)
            begin
                nack_err <= result.nack;  // status of the last transfer
                if (good_read)
                    rd_data <= result.data;
            end
        end
    end

endmodule

// File: source/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wr_data,
    output eeprom_pkg::ee_byte_t rd_data,
    output logic                 done,
    output logic                 busy,
    output logic                 nack_err,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);

    eeprom_pkg::eeprom_req_t req;
    eeprom_pkg::eeprom_res_t result;
    eeprom_pkg::bus_req_t    bus_req;
    eeprom_pkg::bus_res_t    bus_res;
    logic                    pending;
    logic                    finish;
    logic                    bus_go;
    logic                    bus_done;

    assign busy = pending;

    eeprom_request eeprom_request_inst
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .finish  (finish),
        .req     (req),
        .pending (pending)
    );

    eeprom_sequencer eeprom_sequencer_inst
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .pending  (pending),
        .bus_go   (bus_go),
        .bus_req  (bus_req),
        .bus_done (bus_done),
        .bus_res  (bus_res),
        .finish   (finish),
        .result   (result)
    );

    eeprom_bit_engine eeprom_bit_engine_inst
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .bus_go        (bus_go),
        .bus_req       (bus_req),
        .bus_done      (bus_done),
        .bus_res       (bus_res),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    eeprom_response eeprom_response_inst
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .finish   (finish),
        .result   (result),
        .rd_data  (rd_data),
        .nack_err (nack_err),
        .done     (done)
    );

endmodule

// File: verif/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic ack_off,  // suppress every acknowledge
    output logic sda_pull
);

    localparam int P_IDLE = 0;
    localparam int P_CTRL = 1;
    localparam int P_ADDR = 2;
    localparam int P_DATA = 3;
    localparam int P_SEND = 4;
    localparam int P_DONE = 5;

    eeprom_pkg::ee_byte_t mem [0:2047];
    eeprom_pkg::ee_byte_t shreg;
    eeprom_pkg::ee_addr_t ptr;
    logic                 prev_scl;
    logic                 prev_sda;
    logic                 cur_scl;
    logic                 cur_sda;
    logic                 ack;
    int                   phase;
    int                   next_phase;
    int                   bit_cnt;

    // power-up contents, every address bit takes part
    function automatic eeprom_pkg::ee_byte_t preset_byte(eeprom_pkg::ee_addr_t a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = preset_byte(11'(a));
        sda_pull   = 1'b0;
        prev_scl   = 1'b1;
        prev_sda   = 1'b1;
        phase      = P_IDLE;
        next_phase = P_IDLE;
        bit_cnt    = 0;
    end

    // oversampled on the falling clock, the controller moves its pins on the rising one
    always @(negedge CLK)
    begin
        cur_scl = scl;
        cur_sda = sda;
        if (cur_scl && prev_scl && prev_sda && !cur_sda)
        begin
            phase   = P_CTRL;  // start or repeated start
            bit_cnt = 0;
        end
        else if (cur_scl && prev_scl && !prev_sda && cur_sda)
        begin
            phase    = P_IDLE;  // stop
            sda_pull = 1'b0;
        end
        else if (phase != P_IDLE && phase != P_DONE)
        begin
            if (!prev_scl && cur_scl)
            begin
                if (phase != P_SEND && bit_cnt < 8)
                    shreg = {shreg[6:0], cur_sda};
                bit_cnt = bit_cnt + 1;
            end
            else if (prev_scl && !cur_scl)
            begin
                if (bit_cnt == 8)
                begin
                    ack        = !ack_off;
                    next_phase = P_DONE;
                    case (phase)
                        P_CTRL:
                            if (shreg[7:4] == 4'b1010)  // 24Cxx type code
                            begin
                                ptr[10:8]  = shreg[3:1];
                                next_phase = shreg[0] ? P_SEND : P_ADDR;
                            end
                            else
                                ack = 1'b0;
                        P_ADDR:
                        begin
                            ptr[7:0]   = shreg;
                            next_phase = P_ADDR + 1;
                        end
                        P_DATA:
                            if (ack)
                                mem[ptr] = shreg;
                        default:
                            ack = 1'b0;  // controller answers a sent byte
                    endcase
                    if (!ack)
                        next_phase = P_DONE;
                    sda_pull = ack;
                end
                else if (bit_cnt == 9)
                begin
                    sda_pull = 1'b0;
                    bit_cnt  = 0;
                    phase    = next_phase;
                    if (phase == P_SEND)
                    begin
                        shreg    = mem[ptr];
                        sda_pull = !shreg[7];
                    end
                end
                else if (phase == P_SEND)
                    sda_pull = !shreg[7 - bit_cnt];
            end
        end
        prev_scl = cur_scl;
        prev_sda = cur_sda;
    end

endmodule

// File: verif/eeprom_ctrl_props.sv
`timescale 1ns/1ps

module eeprom_ctrl_props
(
    input logic CLK,
    input logic RESET,
    input logic done,
    input logic busy,
    input logic scl,
    input logic sda_drive_low
);

    done_single: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done stayed high for more than one cycle");

    done_not_busy: assert property (@(posedge CLK) disable iff (RESET) done |-> !busy)
        else $error("done seen while busy");

    // bus parked between transfers
    idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> (scl && !sda_drive_low))
        else $error("bus not released while idle");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_props eeprom_ctrl_props_inst
(
    .CLK           (CLK),
    .RESET         (RESET),
    .done          (done),
    .busy          (busy),
    .scl           (scl),
    .sda_drive_low (sda_drive_low)
);

// File: verif/eeprom_ctrl_tb.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_ctrl_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int BYTE_CYCLES = 36 * `EE_QUARTER_CYCLES + 2;
    localparam int COND_CYCLES = 4 * `EE_QUARTER_CYCLES + 2;
    localparam int XFER_CYCLES = 4 * BYTE_CYCLES + 3 * COND_CYCLES + 8;  // a read is the longest

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_byte_t wr_data;
    eeprom_pkg::ee_byte_t rd_data;
    logic                 done;
    logic                 busy;
    logic                 nack_err;
    logic                 scl;
    logic                 sda_drive_low;
    logic                 sda;
    logic                 model_pull;
    logic                 ack_off;
    eeprom_pkg::ee_byte_t ref_mem [0:2047];
    eeprom_pkg::ee_byte_t last_read;  // value of the last good read
    int                   errors;
    int                   checks;

    assign sda = !(sda_drive_low || model_pull);  // pull-up with either side pulling low

    eeprom_ctrl_top eeprom_ctrl_inst
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wr_data       (wr_data),
        .rd_data       (rd_data),
        .done          (done),
        .busy          (busy),
        .nack_err      (nack_err),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model eeprom_model_inst
    (
        .CLK      (CLK),
        .scl      (scl),
        .sda      (sda),
        .ack_off  (ack_off),
        .sda_pull (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        #(60 * XFER_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in 60 transfer lengths");
        $display("SIMULATION FAILED");
        $finish;
    end

    // same power-up contents as the model
    function automatic eeprom_pkg::ee_byte_t preset_byte(eeprom_pkg::ee_addr_t a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    task automatic check_byte(string name, eeprom_pkg::ee_byte_t actual,
                              eeprom_pkg::ee_byte_t expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch at %0t: %s is 0x%02h, expected 0x%02h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < 2 * XFER_CYCLES)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!done)
        begin
            errors++;
            $display("no done pulse within %0d cycles at %0t", 2 * XFER_CYCLES, $time);
        end
        else
            check_flag("busy", busy, 1'b0);
    endtask

    // one strobe cycle and the wait for done
    task automatic issue_request(logic is_write, eeprom_pkg::ee_addr_t a,
                                 eeprom_pkg::ee_byte_t d);
        wr      = is_write;
        rd      = !is_write;
        addr    = a;
        wr_data = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        wait_done();
    endtask

    task automatic write_mem(eeprom_pkg::ee_addr_t a, eeprom_pkg::ee_byte_t d);
        issue_request(1'b1, a, d);
        ref_mem[a] = d;
        check_flag("nack_err", nack_err, 1'b0);
    endtask

    task automatic read_mem(eeprom_pkg::ee_addr_t a);
        issue_request(1'b0, a, 8'h00);
        check_flag("nack_err", nack_err, 1'b0);
        check_byte("rd_data", rd_data, ref_mem[a]);
        last_read = ref_mem[a];
    endtask

    task automatic reset_values();
        check_flag("scl", scl, 1'b1);
        check_flag("sda_drive_low", sda_drive_low, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack_err", nack_err, 1'b0);
        check_byte("rd_data", rd_data, 8'h00);
    endtask

    task automatic write_then_read();
        write_mem(11'h123, 8'hA5);
        read_mem(11'h123);
    endtask

    // same word address in different blocks
    task automatic walk_block_bits();
        int blocks [3];
        blocks = '{0, 3, 7};
        foreach (blocks[i])
            write_mem({3'(blocks[i]), 8'h55}, 8'h30 + 8'(blocks[i]));
        foreach (blocks[i])
            read_mem({3'(blocks[i]), 8'h55});
    endtask

    task automatic drop_busy_request();
        int dones;
        dones = 0;
        wr      = 1'b1;
        addr    = 11'h2A7;
        wr_data = 8'h5C;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        repeat (4)
        begin
            @(posedge CLK);
            #1;
        end
        check_flag("busy", busy, 1'b1);
        rd   = 1'b1;
        addr = 11'h000;
        @(posedge CLK);
        #1;
        rd = 1'b0;
        repeat (2 * XFER_CYCLES)  // room for a second transfer if the read got through
        begin
            @(posedge CLK);
            #1;
            if (done)
                dones++;
        end
        checks++;
        if (dones != 1)
        begin
            errors++;
            $display("expected one done around the dropped read, saw %0d", dones);
        end
        ref_mem[11'h2A7] = 8'h5C;
        read_mem(11'h2A7);
    endtask

    task automatic suppress_ack();
        ack_off = 1'b1;
        issue_request(1'b0, 11'h123, 8'h00);
        check_flag("nack_err", nack_err, 1'b1);
        check_byte("rd_data", rd_data, last_read);
        ack_off = 1'b0;
        read_mem(11'h123);
    endtask

    task automatic random_traffic();
        eeprom_pkg::ee_addr_t a;
        eeprom_pkg::ee_byte_t d;
        repeat (30)
        begin
            a = 11'($urandom_range(2047));
            d = 8'($urandom);
            if ($urandom_range(1) == 1)
                write_mem(a, d);
            else
                read_mem(a);
        end
    endtask

    initial
    begin
        void'($urandom(14));
        errors    = 0;
        checks    = 0;
        last_read = 8'h00;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        ack_off   = 1'b0;
        for (int a = 0; a < 2048; a++)
            ref_mem[a] = preset_byte(11'(a));
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        reset_values();
        write_then_read();
        walk_block_bits();
        drop_busy_request();
        suppress_ack();
        random_traffic();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/eeprom_pkg.sv
source/eeprom_request.sv
source/eeprom_sequencer.sv
source/eeprom_bit_engine.sv
source/eeprom_response.sv
source/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/eeprom_ctrl_props.sv
verif/eeprom_ctrl_tb.sv

// File: Makefile
TOP = eeprom_ctrl_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
